// File: cpu_axi.f
+incdir+testbench
verilog/axi_pkg.sv
verilog/axi_arbiter.sv
verilog/ifu_fetch.sv
verilog/lsu_axi.sv
verilog/axi_sram.sv
verilog/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// File: testbench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Included inside tb_mem_subsys after the package import, so DATA_W and axi_resp_e resolve

// Ends the run, the reason goes first on its own line
task automatic fail_run(input string msg);
   $display("%s", msg);
   $display("test failed");
   $fatal(1);
endtask

// Data word returned by a load or a fetch beat
task automatic check_data(
   input string             name,
   input logic [DATA_W-1:0] exp,
   input logic [DATA_W-1:0] act
);
   if (act !== exp) begin  // Catches X as a mismatch too
      fail_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
   end
endtask

// Response code of a load, a store or a fetch beat
task automatic check_resp(
   input string     name,
   input axi_resp_e exp,
   input axi_resp_e act
);
   if (act !== exp) begin
      // Name and raw bits both shown, an illegal code has no name
      fail_run($sformatf("ERR %s: expected %s (%b), actual %s (%b)",
                         name, exp.name(), exp, act.name(), act));
   end
endtask

// Single-bit status outputs such as busy, done and last
task automatic check_flag(
   input string name,
   input logic  exp,
   input logic  act
);
   if (act !== exp) begin
      fail_run($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
   end
endtask

`endif

// File: testbench/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
   import axi_pkg::*;

   localparam int FETCH_BEATS = 4;
   localparam int MEM_WORDS   = 64;
   localparam int FILL_WORDS  = 32;  // Words written by the fill phase
   localparam int NUM_LOADS   = 16;
   localparam int NUM_PARTIAL = 12;  // Each one is a store and a load
   localparam int NUM_FETCH   = 4;
   localparam int NUM_PAIRS   = 4;   // Fetch and load issued together
   // Every request of the run including three range requests and a reload of all filled words
   localparam int NUM_REQS = FILL_WORDS + NUM_LOADS + 2 * NUM_PARTIAL + NUM_FETCH
                             + 2 * NUM_PAIRS + 3 + FILL_WORDS;
   localparam int TIMEOUT_CYCLES = 200 * NUM_REQS + 100;

   logic              clk;
   logic              rst;
   logic              fetch_req;
   logic [ADDR_W-1:0] fetch_addr;
   logic              fetch_busy;
   logic              fetch_valid;
   logic [DATA_W-1:0] fetch_data;
   axi_resp_e         fetch_resp;
   logic              fetch_last;
   logic              lsu_req;
   lsu_op_e           lsu_op;
   logic [ADDR_W-1:0] lsu_addr;
   logic [DATA_W-1:0] lsu_wdata;
   logic [STRB_W-1:0] lsu_wstrb;
   logic              lsu_busy;
   logic              lsu_done;
   logic [DATA_W-1:0] lsu_rdata;
   axi_resp_e         lsu_resp;

   logic [DATA_W-1:0] model_mem [int];  // Reference contents by word index
   int                idx;
   int                line;
   logic [DATA_W-1:0] exp_word;

   mem_subsys_top #(
      .FETCH_BEATS(FETCH_BEATS),
      .MEM_WORDS  (MEM_WORDS)
   ) dut_i (.*);

   `include "tb_checks.svh"

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // 20 ns period
   end

   // Bound on the whole run from the number of requests
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      fail_run($sformatf("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES));
   end

   // Bytes with a strobe bit take the new data and the rest keep the old word
   function automatic logic [DATA_W-1:0] merge_bytes(
      input logic [DATA_W-1:0] old_word,
      input logic [DATA_W-1:0] data,
      input logic [STRB_W-1:0] strb
   );
      logic [DATA_W-1:0] result;
      result = old_word;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            result[8*b +: 8] = data[8*b +: 8];
         end
      end
      return result;
   endfunction

   function automatic logic [DATA_W-1:0] model_word(input int word);
      if (model_mem.exists(word)) begin
         return model_mem[word];
      end
      return '0;  // Only reached before the first store to a word
   endfunction

   // Word indices at or above the depth answer with SLVERR
   function automatic axi_resp_e resp_for(input int word);
      return (word < MEM_WORDS) ? RESP_OKAY : RESP_SLVERR;
   endfunction

   task automatic start_fetch(input logic [ADDR_W-1:0] addr);
      while (fetch_busy) @(negedge clk);
      @(posedge clk);
      fetch_req  <= 1'b1;
      fetch_addr <= addr;
      @(posedge clk);
      fetch_req  <= 1'b0;  // One cycle pulse
   endtask

   task automatic start_lsu(
      input lsu_op_e           op,
      input logic [ADDR_W-1:0] addr,
      input logic [DATA_W-1:0] data,
      input logic [STRB_W-1:0] strb
   );
      while (lsu_busy) @(negedge clk);
      @(posedge clk);
      lsu_req   <= 1'b1;
      lsu_op    <= op;
      lsu_addr  <= addr;
      lsu_wdata <= data;
      lsu_wstrb <= strb;
      @(posedge clk);
      lsu_req   <= 1'b0;
   endtask

   // Beats are sampled mid-cycle and each is checked against the word it should cover
   task automatic wait_fetch(input string name, input logic [ADDR_W-1:0] addr);
      int word;
      int beat;
      beat = 0;
      while (beat < FETCH_BEATS) begin
         @(negedge clk);
         if (fetch_valid) begin
            word = int'(addr >> 3) + beat;
            check_data($sformatf("%s beat %0d", name, beat),
                       (word < MEM_WORDS) ? model_word(word) : '0, fetch_data);
            check_resp($sformatf("%s beat %0d resp", name, beat), resp_for(word), fetch_resp);
            check_flag($sformatf("%s beat %0d last", name, beat),
                       beat == FETCH_BEATS - 1, fetch_last);
            beat++;
         end
      end
   endtask

   task automatic wait_lsu(
      input string             name,
      input logic              has_data,  // Load result to compare
      input logic [DATA_W-1:0] exp_data,
      input axi_resp_e         exp_resp
   );
      @(negedge clk);
      while (!lsu_done) @(negedge clk);
      check_resp($sformatf("%s resp", name), exp_resp, lsu_resp);
      if (has_data) begin
         check_data(name, exp_data, lsu_rdata);
      end
   endtask

   task automatic run_store(
      input string             name,
      input int                word,
      input logic [DATA_W-1:0] data,
      input logic [STRB_W-1:0] strb
   );
      start_lsu(LSU_STORE, ADDR_W'(word * 8), data, strb);
      wait_lsu(name, 1'b0, '0, resp_for(word));
      if (word < MEM_WORDS) begin
         model_mem[word] = merge_bytes(model_word(word), data, strb);
      end
   endtask

   task automatic run_load(input string name, input int word);
      start_lsu(LSU_LOAD, ADDR_W'(word * 8), '0, '0);
      wait_lsu(name, 1'b1, (word < MEM_WORDS) ? model_word(word) : '0, resp_for(word));
   endtask

   initial begin
      void'($urandom(41083));  // One fixed seed for the whole run
      rst        = 1'b1;
      fetch_req  = 1'b0;
      fetch_addr = '0;
      lsu_req    = 1'b0;
      lsu_op     = LSU_LOAD;
      lsu_addr   = '0;
      lsu_wdata  = '0;
      lsu_wstrb  = '0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;

      @(negedge clk);
      check_flag("reset fetch_busy", 1'b0, fetch_busy);
      check_flag("reset lsu_busy", 1'b0, lsu_busy);
      check_flag("reset fetch_valid", 1'b0, fetch_valid);
      check_flag("reset lsu_done", 1'b0, lsu_done);

      // Full words go first so every later read hits written memory
      for (int i = 0; i < FILL_WORDS; i++) begin
         run_store("fill store", i, {$urandom, $urandom}, 8'hff);
      end
      for (int i = 0; i < NUM_LOADS; i++) begin
         run_load("full load", $urandom % FILL_WORDS);
      end

      for (int i = 0; i < NUM_PARTIAL; i++) begin
         idx = $urandom % FILL_WORDS;
         run_store("partial store", idx, {$urandom, $urandom}, 8'($urandom));
         run_load("partial load", idx);
      end

      for (int i = 0; i < NUM_FETCH; i++) begin
         line = $urandom % (FILL_WORDS / FETCH_BEATS);
         start_fetch(ADDR_W'(line * FETCH_BEATS * 8));
         wait_fetch("fetch", ADDR_W'(line * FETCH_BEATS * 8));
      end

      // Both requests leave on the same edge and fetch wins the bus
      for (int i = 0; i < NUM_PAIRS; i++) begin
         line     = $urandom % (FILL_WORDS / FETCH_BEATS);
         idx      = $urandom % FILL_WORDS;
         exp_word = model_word(idx);
         fork
            start_fetch(ADDR_W'(line * FETCH_BEATS * 8));
            start_lsu(LSU_LOAD, ADDR_W'(idx * 8), '0, '0);
         join
         fork
            wait_fetch("paired fetch", ADDR_W'(line * FETCH_BEATS * 8));
            wait_lsu("paired load", 1'b1, exp_word, RESP_OKAY);
         join
      end

      // Out of range word whose low index bits alias a filled word
      idx = $urandom % FILL_WORDS;
      run_store("range store", MEM_WORDS + idx, {$urandom, $urandom}, 8'hff);
      run_load("range load", MEM_WORDS + ($urandom % MEM_WORDS));
      line = $urandom % (MEM_WORDS / FETCH_BEATS);
      start_fetch(ADDR_W'((MEM_WORDS + line * FETCH_BEATS) * 8));
      wait_fetch("range fetch", ADDR_W'((MEM_WORDS + line * FETCH_BEATS) * 8));
      for (int i = 0; i < FILL_WORDS; i++) begin
         run_load("reload after range", i);  // Nothing inside the range moved
      end

      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/axi_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_arbiter (
   input  wire                   clk,
   input  wire                   rst,
   // Fetch unit, read only
   input  wire axi_pkg::axi_ar_t ifu_ar,
   input  wire                   ifu_arvalid,
   output logic                  ifu_arready,
   output axi_pkg::axi_r_t       ifu_r,
   output logic                  ifu_rvalid,
   input  wire                   ifu_rready,
   // Load/store unit
   input  wire axi_pkg::axi_ar_t lsu_ar,
   input  wire                   lsu_arvalid,
   output logic                  lsu_arready,
   output axi_pkg::axi_r_t       lsu_r,
   output logic                  lsu_rvalid,
   input  wire                   lsu_rready,
   input  wire axi_pkg::axi_ar_t lsu_aw,
   input  wire                   lsu_awvalid,
   output logic                  lsu_awready,
   input  wire axi_pkg::axi_w_t  lsu_w,
   input  wire                   lsu_wvalid,
   output logic                  lsu_wready,
   output axi_pkg::axi_b_t       lsu_b,
   output logic                  lsu_bvalid,
   input  wire                   lsu_bready,
   // Shared bus towards the SRAM
   output axi_pkg::axi_ar_t      bus_ar,
   output logic                  bus_arvalid,
   input  wire                   bus_arready,
   input  wire axi_pkg::axi_r_t  bus_r,
   input  wire                   bus_rvalid,
   output logic                  bus_rready,
   output axi_pkg::axi_ar_t      bus_aw,
   output logic                  bus_awvalid,
   input  wire                   bus_awready,
   output axi_pkg::axi_w_t       bus_w,
   output logic                  bus_wvalid,
   input  wire                   bus_wready,
   input  wire axi_pkg::axi_b_t  bus_b,
   input  wire                   bus_bvalid,
   output logic                  bus_bready
);
   import axi_pkg::*;

   arb_state_e state_q;
   arb_state_e state_d;
   logic       idle;     // No read burst in flight
   logic       ar_hs;    // Request taken by the SRAM this cycle
   logic       r_done;   // Final beat of the burst taken this cycle

   assign idle   = (state_q == ARB_IDLE);
   assign ar_hs  = bus_arvalid && bus_arready;
   assign r_done = bus_rvalid && bus_rready && bus_r.last;

   // The grant is fixed at the address handshake and held through the last beat
   always_comb begin
      state_d = state_q;
      case (state_q)
         ARB_IDLE: begin
            if (ar_hs) begin
               state_d = ifu_arvalid ? ARB_IFU : ARB_LSU;  // Fetch wins a tie
            end
         end
         ARB_IFU, ARB_LSU: begin
            if (r_done) begin
               state_d = ARB_IDLE;
            end
         end
         default: state_d = ARB_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= ARB_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Only one request is offered at a time, and none while a burst is open
   assign bus_arvalid = idle && (ifu_arvalid || lsu_arvalid);
   assign bus_ar      = ifu_arvalid ? ifu_ar : lsu_ar;
   assign ifu_arready = idle && ifu_arvalid && bus_arready;
   assign lsu_arready = idle && !ifu_arvalid && bus_arready;  // Stalled behind fetch

   // Read data goes to the owner of the grant, the other side sees nothing
   assign ifu_rvalid = (state_q == ARB_IFU) && bus_rvalid;
   assign ifu_r      = (state_q == ARB_IFU) ? bus_r : '0;
   assign lsu_rvalid = (state_q == ARB_LSU) && bus_rvalid;
   assign lsu_r      = (state_q == ARB_LSU) ? bus_r : '0;

   always_comb begin
      case (state_q)
         ARB_IFU: bus_rready = ifu_rready;
         ARB_LSU: bus_rready = lsu_rready;
         default: bus_rready = 1'b0;
      endcase
   end

   // Writes only come from the load/store unit and need no arbitration
   assign bus_aw      = lsu_aw;
   assign bus_awvalid = lsu_awvalid;
   assign lsu_awready = bus_awready;
   assign bus_w       = lsu_w;
   assign bus_wvalid  = lsu_wvalid;
   assign lsu_wready  = bus_wready;
   assign lsu_b       = bus_b;
   assign lsu_bvalid  = bus_bvalid;
   assign bus_bready  = lsu_bready;

endmodule

`default_nettype wire

// File: verilog/axi_pkg.sv
`default_nettype none

package axi_pkg;

   localparam int ADDR_W = 32;  // Byte address
   localparam int DATA_W = 64;  // One bus beat
   localparam int STRB_W = 8;   // One strobe bit per data byte

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axi_resp_e;

   // FIXED and WRAP are accepted on the bus but the SRAM walks every burst as INCR
   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10
   } axi_burst_e;

   typedef enum logic {
      LSU_LOAD  = 1'b0,
      LSU_STORE = 1'b1
   } lsu_op_e;

   // Owner of the shared read channels
   typedef enum logic [1:0] {
      ARB_IDLE = 2'b00,
      ARB_IFU  = 2'b01,
      ARB_LSU  = 2'b10
   } arb_state_e;

   // Address request, shared by AR and AW
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [7:0]        len;    // Beats minus one
      logic [2:0]        size;   // Log2 of bytes per beat
      axi_burst_e        burst;
   } axi_ar_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      axi_resp_e         resp;
      logic              last;
   } axi_r_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              last;
   } axi_w_t;

   typedef struct packed {
      axi_resp_e resp;
   } axi_b_t;

endpackage

`default_nettype wire

// File: verilog/axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram #(
   parameter int MEM_WORDS = 256
) (
   input  wire                   clk,
   input  wire                   rst,
   input  wire axi_pkg::axi_ar_t bus_ar,
   input  wire                   bus_arvalid,
   output logic                  bus_arready,
   output axi_pkg::axi_r_t       bus_r,
   output logic                  bus_rvalid,
   input  wire                   bus_rready,
   input  wire axi_pkg::axi_ar_t bus_aw,
   input  wire                   bus_awvalid,
   output logic                  bus_awready,
   input  wire axi_pkg::axi_w_t  bus_w,
   input  wire                   bus_wvalid,
   output logic                  bus_wready,
   output axi_pkg::axi_b_t       bus_b,
   output logic                  bus_bvalid,
   input  wire                   bus_bready
);
   import axi_pkg::*;

   localparam int IDX_W   = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
   localparam int BYTE_SH = $clog2(STRB_W);  // Byte offset bits within a word

   typedef enum logic [1:0] {
      WR_ADDR,
      WR_DATA,
      WR_RESP
   } wr_state_e;

   logic [DATA_W-1:0] mem [MEM_WORDS];

   // Whole word index is compared, so high address bits cannot alias
   function automatic logic in_range(input logic [ADDR_W-1:0] addr);
      return (addr >> BYTE_SH) < MEM_WORDS;
   endfunction

   function automatic logic [IDX_W-1:0] word_idx(input logic [ADDR_W-1:0] addr);
      return addr[IDX_W+BYTE_SH-1:BYTE_SH];
   endfunction

   logic              rd_busy;   // A burst is being returned
   logic [ADDR_W-1:0] rd_addr;   // Address of the beat now on the bus
   logic [7:0]        rd_cnt;    // Beats still to follow it
   logic              ar_hs;
   logic              r_hs;
   logic              r_load;    // Fetch the next beat into the output register
   logic [ADDR_W-1:0] nxt_addr;
   logic [7:0]        nxt_cnt;

   assign bus_arready = !rd_busy;
   assign bus_rvalid  = rd_busy;  // First beat shows the cycle after AR
   assign ar_hs       = bus_arvalid && bus_arready;
   assign r_hs        = bus_rvalid && bus_rready;
   assign r_load      = ar_hs || (r_hs && !bus_r.last);

   // Every burst type walks up by one word per beat
   assign nxt_addr = rd_busy ? rd_addr + ADDR_W'(STRB_W) : bus_ar.addr;
   assign nxt_cnt  = rd_busy ? rd_cnt - 8'd1 : bus_ar.len;

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_busy <= 1'b0;
      end else if (ar_hs) begin
         rd_busy <= 1'b1;
      end else if (r_hs && bus_r.last) begin
         rd_busy <= 1'b0;
      end
   end

   // A beat not taken keeps its register, so it stays on the bus
   always_ff @(posedge clk) begin
      if (r_load) begin
         rd_addr    <= nxt_addr;
         rd_cnt     <= nxt_cnt;
         bus_r.last <= (nxt_cnt == 8'd0);
         if (in_range(nxt_addr)) begin
            bus_r.data <= mem[word_idx(nxt_addr)];
            bus_r.resp <= RESP_OKAY;
         end else begin
            bus_r.data <= '0;
            bus_r.resp <= RESP_SLVERR;
         end
      end
   end

   wr_state_e         wr_state;
   logic [ADDR_W-1:0] wr_addr;

   // Write path runs AW, then W, then B, one transaction at a time
   assign bus_awready = (wr_state == WR_ADDR);
   assign bus_wready  = (wr_state == WR_DATA);
   assign bus_bvalid  = (wr_state == WR_RESP);

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_state <= WR_ADDR;
      end else begin
         case (wr_state)
            WR_ADDR: begin
               if (bus_awvalid) begin
                  wr_state <= WR_DATA;
               end
            end
            WR_DATA: begin
               if (bus_wvalid) begin
                  wr_state <= WR_RESP;  // B rises the cycle after W
               end
            end
            WR_RESP: begin
               if (bus_bready) begin
                  wr_state <= WR_ADDR;
               end
            end
            default: wr_state <= WR_ADDR;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (bus_awvalid && bus_awready) begin
         wr_addr <= bus_aw.addr;
      end
      if (bus_wvalid && bus_wready) begin
         bus_b.resp <= in_range(wr_addr) ? RESP_OKAY : RESP_SLVERR;
         if (in_range(wr_addr)) begin
            for (int i = 0; i < STRB_W; i++) begin
               if (bus_w.strb[i]) begin
                  mem[word_idx(wr_addr)][8*i +: 8] <= bus_w.data[8*i +: 8];
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/ifu_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_fetch #(
   parameter int FETCH_BEATS = 4
) (
   input  wire                         clk,
   input  wire                         rst,
   input  wire                         fetch_req,
   input  wire [axi_pkg::ADDR_W-1:0]   fetch_addr,
   output logic                        fetch_busy,
   output logic                        fetch_valid,
   output logic [axi_pkg::DATA_W-1:0]  fetch_data,
   output axi_pkg::axi_resp_e          fetch_resp,
   output logic                        fetch_last,
   output axi_pkg::axi_ar_t            ifu_ar,
   output logic                        ifu_arvalid,
   input  wire                         ifu_arready,
   input  wire axi_pkg::axi_r_t        ifu_r,
   input  wire                         ifu_rvalid,
   output logic                        ifu_rready
);
   import axi_pkg::*;

   localparam int                LINE_BYTES = FETCH_BEATS * STRB_W;
   localparam logic [ADDR_W-1:0] LINE_MASK  = ADDR_W'(LINE_BYTES - 1);

   logic              start;      // Request accepted this cycle
   logic [ADDR_W-1:0] line_addr;  // Start of the line being fetched

   assign start = fetch_req && !fetch_busy;

   always_ff @(posedge clk) begin
      if (rst) begin
         fetch_busy  <= 1'b0;
         ifu_arvalid <= 1'b0;
      end else if (start) begin
         fetch_busy  <= 1'b1;
         ifu_arvalid <= 1'b1;  // Address goes out one cycle after the pulse
      end else begin
         if (ifu_arvalid && ifu_arready) begin
            ifu_arvalid <= 1'b0;
         end
         if (ifu_rvalid && ifu_rready && ifu_r.last) begin
            fetch_busy <= 1'b0;  // Free again the cycle after the last beat
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         line_addr <= fetch_addr & ~LINE_MASK;
      end
   end

   // One INCR burst covers the whole line, eight bytes per beat
   assign ifu_ar = '{addr: line_addr, len: 8'(FETCH_BEATS - 1), size: 3'd3, burst: BURST_INCR};

   // Beats stream straight out with no buffering
   assign ifu_rready  = 1'b1;
   assign fetch_valid = ifu_rvalid;
   assign fetch_data  = ifu_r.data;
   assign fetch_resp  = ifu_r.resp;
   assign fetch_last  = ifu_rvalid && ifu_r.last;

endmodule

`default_nettype wire

// File: verilog/lsu_axi.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_axi (
   input  wire                         clk,
   input  wire                         rst,
   input  wire                         lsu_req,
   input  wire axi_pkg::lsu_op_e       lsu_op,
   input  wire [axi_pkg::ADDR_W-1:0]   lsu_addr,
   input  wire [axi_pkg::DATA_W-1:0]   lsu_wdata,
   input  wire [axi_pkg::STRB_W-1:0]   lsu_wstrb,
   output logic                        lsu_busy,
   output logic                        lsu_done,
   output logic [axi_pkg::DATA_W-1:0]  lsu_rdata,
   output axi_pkg::axi_resp_e          lsu_resp,
   output axi_pkg::axi_ar_t            lsu_ar,
   output logic                        lsu_arvalid,
   input  wire                         lsu_arready,
   input  wire axi_pkg::axi_r_t        lsu_r,
   input  wire                         lsu_rvalid,
   output logic                        lsu_rready,
   output axi_pkg::axi_ar_t            lsu_aw,
   output logic                        lsu_awvalid,
   input  wire                         lsu_awready,
   output axi_pkg::axi_w_t             lsu_w,
   output logic                        lsu_wvalid,
   input  wire                         lsu_wready,
   input  wire axi_pkg::axi_b_t        lsu_b,
   input  wire                         lsu_bvalid,
   output logic                        lsu_bready
);
   import axi_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ADDR,  // Address (and store data) offered
      ST_DATA,  // Load waits for its R beat
      ST_RESP   // Store waits for its B response
   } lsu_state_e;

   lsu_state_e        state;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdata_q;
   logic [STRB_W-1:0] wstrb_q;
   logic              aw_left;  // AW still pending after this cycle
   logic              w_left;   // W still pending after this cycle
   logic              r_hs;
   logic              b_hs;

   assign aw_left = lsu_awvalid && !lsu_awready;
   assign w_left  = lsu_wvalid && !lsu_wready;
   assign r_hs    = lsu_rvalid && lsu_rready;
   assign b_hs    = lsu_bvalid && lsu_bready;

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= ST_IDLE;
         lsu_arvalid <= 1'b0;
         lsu_awvalid <= 1'b0;
         lsu_wvalid  <= 1'b0;
         lsu_done    <= 1'b0;
      end else begin
         lsu_done <= 1'b0;  // Single cycle pulse
         case (state)
            ST_IDLE: begin
               if (lsu_req) begin
                  state       <= ST_ADDR;
                  lsu_arvalid <= (lsu_op == LSU_LOAD);
                  lsu_awvalid <= (lsu_op == LSU_STORE);  // AW and W rise together
                  lsu_wvalid  <= (lsu_op == LSU_STORE);
               end
            end
            ST_ADDR: begin
               if (lsu_arvalid) begin
                  if (lsu_arready) begin
                     lsu_arvalid <= 1'b0;
                     state       <= ST_DATA;
                  end
               end else begin
                  // Each write channel lets go on its own handshake
                  lsu_awvalid <= aw_left;
                  lsu_wvalid  <= w_left;
                  if (!aw_left && !w_left) begin
                     state <= ST_RESP;
                  end
               end
            end
            ST_DATA: begin
               if (r_hs) begin
                  state    <= ST_IDLE;
                  lsu_done <= 1'b1;
               end
            end
            ST_RESP: begin
               if (b_hs) begin
                  state    <= ST_IDLE;
                  lsu_done <= 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Request payload and results
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && lsu_req) begin
         addr_q  <= lsu_addr;
         wdata_q <= lsu_wdata;
         wstrb_q <= lsu_wstrb;
      end
      if (r_hs) begin
         lsu_rdata <= lsu_r.data;
         lsu_resp  <= lsu_r.resp;
      end
      if (b_hs) begin
         lsu_resp <= lsu_b.resp;
      end
   end

   assign lsu_busy = (state != ST_IDLE);

   // Single beat of eight bytes, same request shape for load and store
   assign lsu_ar = '{addr: addr_q, len: 8'd0, size: 3'd3, burst: BURST_INCR};
   assign lsu_aw = lsu_ar;
   assign lsu_w  = '{data: wdata_q, strb: wstrb_q, last: 1'b1};

   assign lsu_rready = 1'b1;
   assign lsu_bready = 1'b1;

endmodule

`default_nettype wire

// File: verilog/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
   parameter int FETCH_BEATS = 4,
   parameter int MEM_WORDS   = 256
) (
   input  wire                         clk,
   input  wire                         rst,
   // Instruction fetch
   input  wire                         fetch_req,
   input  wire [axi_pkg::ADDR_W-1:0]   fetch_addr,
   output logic                        fetch_busy,
   output logic                        fetch_valid,
   output logic [axi_pkg::DATA_W-1:0]  fetch_data,
   output axi_pkg::axi_resp_e          fetch_resp,
   output logic                        fetch_last,
   // Loads and stores
   input  wire                         lsu_req,
   input  wire axi_pkg::lsu_op_e       lsu_op,
   input  wire [axi_pkg::ADDR_W-1:0]   lsu_addr,
   input  wire [axi_pkg::DATA_W-1:0]   lsu_wdata,
   input  wire [axi_pkg::STRB_W-1:0]   lsu_wstrb,
   output logic                        lsu_busy,
   output logic                        lsu_done,
   output logic [axi_pkg::DATA_W-1:0]  lsu_rdata,
   output axi_pkg::axi_resp_e          lsu_resp
);
   import axi_pkg::*;

   // Fetch unit to arbiter
   axi_ar_t ifu_ar;
   axi_r_t  ifu_r;
   logic    ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;

   // Load/store unit to arbiter
   axi_ar_t lsu_ar, lsu_aw;
   axi_r_t  lsu_r;
   axi_w_t  lsu_w;
   axi_b_t  lsu_b;
   logic    lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
   logic    lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;

   // Arbiter to SRAM
   axi_ar_t bus_ar, bus_aw;
   axi_r_t  bus_r;
   axi_w_t  bus_w;
   axi_b_t  bus_b;
   logic    bus_arvalid, bus_arready, bus_rvalid, bus_rready;
   logic    bus_awvalid, bus_awready, bus_wvalid, bus_wready, bus_bvalid, bus_bready;

   // Port names match the nets above one for one
   ifu_fetch #(.FETCH_BEATS(FETCH_BEATS)) ifu_fetch_i (.*);

   lsu_axi lsu_axi_i (.*);

   axi_arbiter axi_arbiter_i (.*);

   axi_sram #(.MEM_WORDS(MEM_WORDS)) axi_sram_i (.*);

endmodule

`default_nettype wire
